// ==== Makefile ====
LOG := sim.log

all: run

build: obj_dir/Vtb_cpu_bus

obj_dir/Vtb_cpu_bus: vlog.f rtl/*.sv rtl/*.svh test/*.sv
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_cpu_bus -Mdir obj_dir -f vlog.f

# Pass only when the testbench printed its pass line
run: build
	./obj_dir/Vtb_cpu_bus | tee $(LOG)
	grep -qx "TEST PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all build run clean

// ==== rtl/bus_decoder.sv ====
`timescale 1ns/1ps
`include "cpu_bus_macros.svh"

module bus_decoder
	import cpu_bus_pkg::*;
(
	// From the arbiter
	input logic i_bus_request,
	input bus_req_t i_bus_req,
	output logic o_bus_ready,
	output logic [`CPU_BUS_DATA_W-1:0] o_bus_rdata,

	// SRAM slave
	output logic o_mem_request,
	output bus_req_t o_mem_req,
	input logic i_mem_ready,
	input logic [`CPU_BUS_DATA_W-1:0] i_mem_rdata,

	// Timing register block
	output logic o_reg_request,
	output bus_req_t o_reg_req,
	input logic i_reg_ready,
	input logic [`CPU_BUS_DATA_W-1:0] i_reg_rdata
);

	localparam logic [`CPU_BUS_ADDR_W-1:0] REG_BASE_ADDR = `REG_BASE;

	logic reg_sel;

	// Only the upper half of the address takes part in the match
	assign reg_sel = (i_bus_req.address[`CPU_BUS_ADDR_W-1:`CPU_BUS_ADDR_W-16]
		== REG_BASE_ADDR[`CPU_BUS_ADDR_W-1:`CPU_BUS_ADDR_W-16]);

	assign o_mem_request = i_bus_request && !reg_sel;
	assign o_reg_request = i_bus_request && reg_sel;

	// Both slaves see the same access, only one gets the request
	assign o_mem_req = i_bus_req;
	assign o_reg_req = i_bus_req;

	assign o_bus_ready = reg_sel ? i_reg_ready : i_mem_ready;
	assign o_bus_rdata = reg_sel ? i_reg_rdata : i_mem_rdata;

endmodule

// ==== rtl/bus_timing_regs.sv ====
`timescale 1ns/1ps
`include "cpu_bus_macros.svh"

module bus_timing_regs
	import cpu_bus_pkg::*;
(
	input logic i_clock,
	input logic i_reset,

	input logic i_reg_request,
	input bus_req_t i_reg_req,
	output logic o_reg_ready,
	output logic [`CPU_BUS_DATA_W-1:0] o_reg_rdata,

	input logic i_access_done, // One pulse per finished SRAM access
	output logic [`WAIT_W-1:0] o_wait_states
);

	logic [`WAIT_W-1:0] wait_q;
	logic [`CPU_BUS_DATA_W-1:0] count_q;
	logic [15:0] offset;
	logic take;

	assign offset = i_reg_req.address[15:0];
	assign take = i_reg_request && !o_reg_ready; // Ready edge ends the access
	assign o_wait_states = wait_q;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_reg_ready <= 1'b0;
			wait_q <= '0;
			count_q <= '0;
		end else begin
			o_reg_ready <= take;
			if (i_access_done) begin
				count_q <= count_q + 1'b1;
			end
			// Counter is read only
			if (take && i_reg_req.rw && offset == `REG_WAIT_OFS) begin
				wait_q <= i_reg_req.wdata[`WAIT_W-1:0];
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (take) begin
			case (offset)
				`REG_WAIT_OFS: o_reg_rdata <= {{(`CPU_BUS_DATA_W-`WAIT_W){1'b0}}, wait_q};
				`REG_COUNT_OFS: o_reg_rdata <= count_q;
				default: o_reg_rdata <= '0;
			endcase
		end
	end

endmodule

// ==== rtl/cpu_bus_arbiter.sv ====
`timescale 1ns/1ps
`include "cpu_bus_macros.svh"

module cpu_bus_arbiter
	import cpu_bus_pkg::*;
(
	input logic i_clock,
	input logic i_reset,

	// Port A, instruction fetch (read only)
	input logic i_pa_request,
	input logic [`CPU_BUS_ADDR_W-1:0] i_pa_address,
	output logic o_pa_ready,
	output logic [`CPU_BUS_DATA_W-1:0] o_pa_rdata,

	// Port B, load/store
	input logic i_pb_request,
	input bus_req_t i_pb_req,
	output logic o_pb_ready,
	output logic [`CPU_BUS_DATA_W-1:0] o_pb_rdata,

	// Port C, debug or DMA
	input logic i_pc_request,
	input bus_req_t i_pc_req,
	output logic o_pc_ready,
	output logic [`CPU_BUS_DATA_W-1:0] o_pc_rdata,

	// Shared bus
	output logic o_bus_request,
	output bus_req_t o_bus_req,
	input logic i_bus_ready,
	input logic [`CPU_BUS_DATA_W-1:0] i_bus_rdata
);

	grant_t state;

	assign o_bus_request = (state != GRANT_IDLE);

	// Ready and data only reach the port that holds the grant
	assign o_pa_ready = (i_pa_request && state == GRANT_A) ? i_bus_ready : 1'b0;
	assign o_pb_ready = (i_pb_request && state == GRANT_B) ? i_bus_ready : 1'b0;
	assign o_pc_ready = (i_pc_request && state == GRANT_C) ? i_bus_ready : 1'b0;

	assign o_pa_rdata = (state == GRANT_A) ? i_bus_rdata : '0;
	assign o_pb_rdata = (state == GRANT_B) ? i_bus_rdata : '0;
	assign o_pc_rdata = (state == GRANT_C) ? i_bus_rdata : '0;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= GRANT_IDLE;
		end else begin
			case (state)
				GRANT_IDLE: begin
					// Fixed priority C > B > A
					if (i_pc_request) begin
						state <= GRANT_C;
					end else if (i_pb_request) begin
						state <= GRANT_B;
					end else if (i_pa_request) begin
						state <= GRANT_A;
					end
				end
				default: begin
					if (i_bus_ready) begin // Access done, free the bus
						state <= GRANT_IDLE;
					end
				end
			endcase
		end
	end

	// Capture the winner's access, held for the whole grant
	always_ff @(posedge i_clock) begin
		if (state == GRANT_IDLE) begin
			if (i_pc_request) begin
				o_bus_req <= i_pc_req;
			end else if (i_pb_request) begin
				o_bus_req <= i_pb_req;
			end else if (i_pa_request) begin
				o_bus_req.rw <= 1'b0; // Fetch is always a read
				o_bus_req.address <= i_pa_address;
				o_bus_req.wdata <= '0;
			end
		end
	end

endmodule

// ==== rtl/cpu_bus_macros.svh ====
`ifndef CPU_BUS_MACROS_SVH
`define CPU_BUS_MACROS_SVH

`define CPU_BUS_ADDR_W 32
`define CPU_BUS_DATA_W 32

// SRAM depth in 32-bit words, as log2
`define SRAM_WORDS_LOG2 10

`define REG_BASE 32'hFFFF_0000 // Upper half selects the register block
`define REG_WAIT_OFS 16'h0000
`define REG_COUNT_OFS 16'h0004
`define WAIT_W 4

`endif

// ==== rtl/cpu_bus_pkg.sv ====
`include "cpu_bus_macros.svh"

package cpu_bus_pkg;

	// One bus access as a master presents it
	typedef struct packed {
		logic rw; // 1 = write
		logic [`CPU_BUS_ADDR_W-1:0] address;
		logic [`CPU_BUS_DATA_W-1:0] wdata;
	} bus_req_t;

	// Arbiter state, which port owns the bus
	typedef enum logic [1:0] {
		GRANT_IDLE = 2'd0,
		GRANT_A = 2'd1,
		GRANT_B = 2'd2,
		GRANT_C = 2'd3
	} grant_t;

endpackage

// ==== rtl/cpu_bus_top.sv ====
`timescale 1ns/1ps
`include "cpu_bus_macros.svh"

module cpu_bus_top
	import cpu_bus_pkg::*;
(
	input logic i_clock,
	input logic i_reset,

	input logic i_pa_request,
	input logic [`CPU_BUS_ADDR_W-1:0] i_pa_address,
	output logic o_pa_ready,
	output logic [`CPU_BUS_DATA_W-1:0] o_pa_rdata,

	input logic i_pb_request,
	input bus_req_t i_pb_req,
	output logic o_pb_ready,
	output logic [`CPU_BUS_DATA_W-1:0] o_pb_rdata,

	input logic i_pc_request,
	input bus_req_t i_pc_req,
	output logic o_pc_ready,
	output logic [`CPU_BUS_DATA_W-1:0] o_pc_rdata
);

	logic bus_request, bus_ready;
	bus_req_t bus_req;
	logic [`CPU_BUS_DATA_W-1:0] bus_rdata;

	logic mem_request, mem_ready;
	bus_req_t mem_req;
	logic [`CPU_BUS_DATA_W-1:0] mem_rdata;

	logic reg_request, reg_ready;
	bus_req_t reg_req;
	logic [`CPU_BUS_DATA_W-1:0] reg_rdata;

	logic [`WAIT_W-1:0] wait_states;
	logic access_done;

	cpu_bus_arbiter u_arbiter (
		.i_clock(i_clock), .i_reset(i_reset),
		.i_pa_request(i_pa_request), .i_pa_address(i_pa_address),
		.o_pa_ready(o_pa_ready), .o_pa_rdata(o_pa_rdata),
		.i_pb_request(i_pb_request), .i_pb_req(i_pb_req),
		.o_pb_ready(o_pb_ready), .o_pb_rdata(o_pb_rdata),
		.i_pc_request(i_pc_request), .i_pc_req(i_pc_req),
		.o_pc_ready(o_pc_ready), .o_pc_rdata(o_pc_rdata),
		.o_bus_request(bus_request), .o_bus_req(bus_req),
		.i_bus_ready(bus_ready), .i_bus_rdata(bus_rdata)
	);

	bus_decoder u_decoder (
		.i_bus_request(bus_request), .i_bus_req(bus_req),
		.o_bus_ready(bus_ready), .o_bus_rdata(bus_rdata),
		.o_mem_request(mem_request), .o_mem_req(mem_req),
		.i_mem_ready(mem_ready), .i_mem_rdata(mem_rdata),
		.o_reg_request(reg_request), .o_reg_req(reg_req),
		.i_reg_ready(reg_ready), .i_reg_rdata(reg_rdata)
	);

	bus_timing_regs u_regs (
		.i_clock(i_clock), .i_reset(i_reset),
		.i_reg_request(reg_request), .i_reg_req(reg_req),
		.o_reg_ready(reg_ready), .o_reg_rdata(reg_rdata),
		.i_access_done(access_done), .o_wait_states(wait_states)
	);

	sram_slave u_sram (
		.i_clock(i_clock), .i_reset(i_reset),
		.i_mem_request(mem_request), .i_mem_req(mem_req),
		.o_mem_ready(mem_ready), .o_mem_rdata(mem_rdata),
		.i_wait_states(wait_states), .o_access_done(access_done)
	);

endmodule

// ==== rtl/sram_slave.sv ====
`timescale 1ns/1ps
`include "cpu_bus_macros.svh"

module sram_slave
	import cpu_bus_pkg::*;
(
	input logic i_clock,
	input logic i_reset,

	input logic i_mem_request,
	input bus_req_t i_mem_req,
	output logic o_mem_ready,
	output logic [`CPU_BUS_DATA_W-1:0] o_mem_rdata,

	input logic [`WAIT_W-1:0] i_wait_states,
	output logic o_access_done
);

	localparam int DEPTH = 1 << `SRAM_WORDS_LOG2;
	localparam logic [`WAIT_W-1:0] LAST_WAIT = 1;

	logic [`CPU_BUS_DATA_W-1:0] mem [DEPTH];
	logic [`SRAM_WORDS_LOG2-1:0] index;
	logic [`WAIT_W-1:0] wait_count;
	logic busy;
	logic start;
	logic finish;

	// Word address, wraps at the memory depth
	assign index = i_mem_req.address[`SRAM_WORDS_LOG2+1:2];

	assign start = i_mem_request && !busy && !o_mem_ready;
	assign finish = (start && i_wait_states == '0) || (busy && wait_count == LAST_WAIT);

	assign o_access_done = o_mem_ready;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			busy <= 1'b0;
			wait_count <= '0;
			o_mem_ready <= 1'b0;
		end else begin
			o_mem_ready <= finish; // High for one cycle only
			if (start && i_wait_states != '0) begin
				busy <= 1'b1;
				wait_count <= i_wait_states;
			end else if (busy) begin
				wait_count <= wait_count - 1'b1;
				if (wait_count == LAST_WAIT) begin
					busy <= 1'b0;
				end
			end
		end
	end

	// Memory array and read word
	always_ff @(posedge i_clock) begin
		if (finish) begin
			if (i_mem_req.rw) begin
				mem[index] <= i_mem_req.wdata;
			end
			o_mem_rdata <= mem[index];
		end
	end

endmodule

// ==== test/tb_cpu_bus.sv ====
`timescale 1ns/1ps
`include "cpu_bus_macros.svh"

module tb_cpu_bus
	import cpu_bus_pkg::*;
();

	localparam int WATCHDOG_NS = 20000; // Full run at 15 wait states is near 6000 ns
	localparam logic [31:0] REG_BASE_ADDR = `REG_BASE;
	localparam logic [31:0] WAIT_REG = REG_BASE_ADDR | 32'(`REG_WAIT_OFS);
	localparam logic [31:0] COUNT_REG = REG_BASE_ADDR | 32'(`REG_COUNT_OFS);
	localparam logic [31:0] SPARE_REG = REG_BASE_ADDR | 32'h8; // No register here

	logic i_clock, i_reset;
	logic i_pa_request, i_pb_request, i_pc_request;
	logic [31:0] i_pa_address;
	bus_req_t i_pb_req, i_pc_req;
	logic o_pa_ready, o_pb_ready, o_pc_ready;
	logic [31:0] o_pa_rdata, o_pb_rdata, o_pc_rdata;

	int errors;
	int cycle;
	int sram_accesses; // Completed SRAM accesses seen on the ports
	logic [31:0] model [int]; // Memory contents by word index
	string ready_order;

	cpu_bus_top dut (.*);

	always #4 i_clock = ~i_clock;

	always @(posedge i_clock) begin
		cycle <= cycle + 1;
	end

	assert property (@(posedge i_clock) $onehot0({o_pa_ready, o_pb_ready, o_pc_ready}))
		else log_error($sformatf("Fail %0t: port readies expected one-hot or zero got %b",
			$time, {o_pa_ready, o_pb_ready, o_pc_ready}));

	// A ready only ever answers a raised request
	assert property (@(posedge i_clock) !(|{o_pa_ready & ~i_pa_request,
		o_pb_ready & ~i_pb_request, o_pc_ready & ~i_pc_request}))
		else log_error($sformatf("Fail %0t: ready without request expected 000 got %b", $time,
			{o_pa_ready & ~i_pa_request, o_pb_ready & ~i_pb_request, o_pc_ready & ~i_pc_request}));

	assert property (@(posedge i_clock) (i_reset || $past(i_reset))
		|-> !(o_pa_ready || o_pb_ready || o_pc_ready))
		else log_error($sformatf("Fail %0t: port readies in reset expected 000 got %b",
			$time, {o_pa_ready, o_pb_ready, o_pc_ready}));

	function automatic void log_error(string line);
		errors++;
		$display("%s", line);
	endfunction

	function automatic void check_word(string name, logic [31:0] expected, logic [31:0] actual);
		assert (actual === expected)
			else log_error($sformatf("Fail %0t: %s expected %0h got %0h",
				$time, name, expected, actual));
	endfunction

	function automatic logic [31:0] stored_word(logic [31:0] address);
		return model[int'(address[`SRAM_WORDS_LOG2+1:2])]; // Wraps at the SRAM depth
	endfunction

	function automatic void record_access(logic rw, logic [31:0] address, logic [31:0] wdata);
		if (address[31:16] != REG_BASE_ADDR[31:16]) begin
			sram_accesses++;
			if (rw) begin
				model[int'(address[`SRAM_WORDS_LOG2+1:2])] = wdata;
			end
		end
	endfunction

	// Latency counts edges from the raise to the cycle where ready is high
	task automatic fetch_a(input logic [31:0] address, output logic [31:0] rdata,
		output int latency);
		int start;
		i_pa_address = address;
		i_pa_request = 1'b1;
		start = cycle;
		@(negedge i_clock);
		while (!o_pa_ready) @(negedge i_clock);
		latency = cycle - start;
		rdata = o_pa_rdata;
		ready_order = {ready_order, "A"};
		record_access(1'b0, address, '0);
		@(posedge i_clock);
		#1 i_pa_request = 1'b0;
		@(posedge i_clock); // Idle cycle before the next access
		#1;
	endtask

	task automatic access_b(input logic rw, input logic [31:0] address,
		input logic [31:0] wdata, output logic [31:0] rdata, output int latency);
		int start;
		i_pb_req = '{rw, address, wdata};
		i_pb_request = 1'b1;
		start = cycle;
		@(negedge i_clock);
		while (!o_pb_ready) @(negedge i_clock);
		latency = cycle - start;
		rdata = o_pb_rdata;
		ready_order = {ready_order, "B"};
		record_access(rw, address, wdata);
		@(posedge i_clock);
		#1 i_pb_request = 1'b0;
		@(posedge i_clock);
		#1;
	endtask

	task automatic access_c(input logic rw, input logic [31:0] address,
		input logic [31:0] wdata, output logic [31:0] rdata, output int latency);
		int start;
		i_pc_req = '{rw, address, wdata};
		i_pc_request = 1'b1;
		start = cycle;
		@(negedge i_clock);
		while (!o_pc_ready) @(negedge i_clock);
		latency = cycle - start;
		rdata = o_pc_rdata;
		ready_order = {ready_order, "C"};
		record_access(rw, address, wdata);
		@(posedge i_clock);
		#1 i_pc_request = 1'b0;
		@(posedge i_clock);
		#1;
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the run did not finish within %0d ns, errors %0d", WATCHDOG_NS, errors);
		$display("TEST FAIL");
		$finish;
	end

	initial begin
		logic [31:0] address, data, rdata, rdata_a, rdata_b;
		int latency, latency_a, latency_b, wait_states;
		void'($urandom(32'hcba1c161));
		i_clock = 1'b0;
		i_reset = 1'b1;
		{i_pa_request, i_pb_request, i_pc_request} = '0;
		i_pa_address = '0;
		i_pb_req = '0;
		i_pc_req = '0;
		errors = 0;
		cycle = 0;
		sram_accesses = 0;
		repeat (2) @(posedge i_clock);
		#1 {i_pa_request, i_pb_request, i_pc_request} = '1; // Pending requests wait out reset
		repeat (8) @(posedge i_clock);
		#1 i_reset = 1'b0;
		{i_pa_request, i_pb_request, i_pc_request} = '0;
		@(posedge i_clock);
		#1;

		access_c(1'b0, WAIT_REG, '0, rdata, latency); // Zero wait states out of reset
		check_word("wait register", '0, rdata);
		check_word("register latency", 2, latency);

		// First pass with no wait states, second with a random count
		wait_states = 0;
		for (int pass = 0; pass < 2; pass++) begin
			if (pass == 1) begin
				wait_states = 1 + int'($urandom % 15);
				access_c(1'b1, WAIT_REG, wait_states, rdata, latency);
				check_word("register latency", 2, latency);
				access_c(1'b0, WAIT_REG, '0, rdata, latency);
				check_word("wait register", wait_states, rdata);
			end
			for (int i = 0; i < 5; i++) begin
				address = $urandom & 32'h7FFF_FFFC;
				data = $urandom;
				access_b(1'b1, address, data, rdata, latency);
				check_word("port B latency", wait_states + 2, latency);
				access_b(1'b0, address, '0, rdata, latency);
				check_word("o_pb_rdata", stored_word(address), rdata);
				fetch_a(address, rdata, latency);
				check_word("o_pa_rdata", stored_word(address), rdata);
				check_word("port A latency", wait_states + 2, latency);
			end
		end

		// All three masters raised together on one word, C writes first
		address = $urandom & 32'h7FFF_FFFC;
		data = $urandom;
		ready_order = "";
		fork
			access_c(1'b1, address, data, rdata, latency);
			access_b(1'b0, address, '0, rdata_b, latency_b);
			fetch_a(address, rdata_a, latency_a);
		join
		assert (ready_order == "CBA")
			else log_error($sformatf("Fail %0t: ready order expected CBA got %s",
				$time, ready_order));
		check_word("port C latency", wait_states + 2, latency);
		// Each later port also waits out the earlier accesses and their idle cycles
		check_word("port B latency", 2 * (wait_states + 2) + 1, latency_b);
		check_word("port A latency", 3 * (wait_states + 2) + 2, latency_a);
		check_word("o_pb_rdata", data, rdata_b);
		check_word("o_pa_rdata", data, rdata_a);

		// SPARE_REG shares its word index with SRAM address 8
		data = $urandom;
		access_b(1'b1, 32'h0000_0008, data, rdata, latency);
		access_c(1'b1, SPARE_REG, ~data, rdata, latency);
		access_c(1'b1, COUNT_REG, 32'hFFFF_FFFF, rdata, latency);
		access_c(1'b0, SPARE_REG, '0, rdata, latency);
		check_word("unused register", '0, rdata);
		foreach (model[idx]) begin
			fetch_a(32'(idx) << 2, rdata, latency);
			check_word("o_pa_rdata", model[idx], rdata);
		end
		access_c(1'b0, COUNT_REG, '0, rdata, latency);
		check_word("access counter", sram_accesses, rdata);

		$display("Errors: %0d", errors);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+rtl
rtl/cpu_bus_pkg.sv
rtl/cpu_bus_arbiter.sv
rtl/bus_decoder.sv
rtl/bus_timing_regs.sv
rtl/sram_slave.sv
rtl/cpu_bus_top.sv
test/tb_cpu_bus.sv
